/* cpu_defs.svh */
// Width and depth macros shared by the 16-bit pipelined processor
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath width and register file shape
`define CPU_XLEN        16
`define CPU_NREGS       8
`define CPU_RIDX_W      3

// Word-addressed memories, indexed by byte address bits AW..1
`define CPU_IMEM_DEPTH  256
`define CPU_IMEM_AW     8
`define CPU_DMEM_DEPTH  256
`define CPU_DMEM_AW     8

`endif

/* decode.sv */
// Decode stage with control generation, register file, immediates and the ID/EX register
`timescale 1ns/100ps
`include "cpu_defs.svh"

module decode (
   input  logic                clk,
   input  logic                arst_n,
   input  pipe_pkg::if_id_t    if_q,
   input  logic                stall,
   input  pipe_pkg::redirect_t redirect,
   input  pipe_pkg::mem_wb_t   wb_q,
   output pipe_pkg::id_ex_t    id_q,
   output pipe_pkg::wb_trace_t trace,
   output logic                err
);
   import isa_pkg::*;
   import pipe_pkg::*;

   logic [`CPU_XLEN-1:0]   regs [`CPU_NREGS];
   instr_t                 ins;
   logic [`CPU_XLEN-1:0]   raw;
   ctrl_t                  ctrl;
   logic                   illegal;
   logic                   bubble;
   logic [`CPU_XLEN-1:0]   imm;
   logic [`CPU_RIDX_W-1:0] wsel;
   logic                   wb_we;
   logic [`CPU_XLEN-1:0]   rs_val;
   logic [`CPU_XLEN-1:0]   rt_val;
   ctrl_t                  ctrl_q;
   logic [`CPU_XLEN-1:0]   pc_next_q;
   logic [`CPU_XLEN-1:0]   rs_val_q;
   logic [`CPU_XLEN-1:0]   rt_val_q;
   logic [`CPU_XLEN-1:0]   imm_q;
   logic [`CPU_RIDX_W-1:0] wsel_q;
   logic                   trace_valid;
   logic [`CPU_RIDX_W-1:0] trace_reg;
   logic [`CPU_XLEN-1:0]   trace_data;

   assign ins = if_q.instr;
   assign raw = if_q.instr;

   always_comb begin
      ctrl        = ctrl_t'('0);
      ctrl.valid  = 1'b1;
      ctrl.branch = BR_NONE;
      ctrl.alu_op = ALU_ADD;
      illegal     = 1'b0;
      imm         = {{(`CPU_XLEN-5){raw[4]}}, raw[4:0]};
      wsel        = ins.rd;
      case (ins.opcode)
         OP_HALT: ctrl.halt = 1'b1;
         OP_NOP:  ;
         OP_ADDI: begin
            ctrl.reg_write   = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            wsel             = ins.rt;
         end
         OP_LD: begin
            ctrl.reg_write   = 1'b1;
            ctrl.mem_read    = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            wsel             = ins.rt;
         end
         OP_ST: begin
            ctrl.mem_write   = 1'b1;
            ctrl.alu_src_imm = 1'b1;
         end
         OP_LBI: begin
            ctrl.reg_write = 1'b1;
            ctrl.imm_pass  = 1'b1;
            imm            = {{(`CPU_XLEN-8){raw[7]}}, raw[7:0]};
            wsel           = ins.rs;
         end
         OP_BEQZ, OP_BNEZ: begin
            ctrl.branch = (ins.opcode == OP_BEQZ) ? BR_ZERO : BR_NONZERO;
            imm         = {{(`CPU_XLEN-8){raw[7]}}, raw[7:0]};
         end
         OP_J: begin
            ctrl.jump = 1'b1;
            imm       = {{(`CPU_XLEN-11){raw[10]}}, raw[10:0]};
         end
         OP_RTYPE: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_op    = ins.funct;
         end
         default: illegal = 1'b1;
      endcase
   end

   // Flushed, stalled and illegal slots all leave as bubbles
   assign bubble = !if_q.valid || illegal || stall || redirect.taken;

   // Register file, written from writeback with same-cycle bypass to the reads
   assign wb_we = wb_q.valid && wb_q.reg_write;

   always_ff @(posedge clk) begin
      if (wb_we) begin
         regs[wb_q.wsel] <= wb_q.wdata;
      end
   end

   assign rs_val = (wb_we && wb_q.wsel == ins.rs) ? wb_q.wdata : regs[ins.rs];
   assign rt_val = (wb_we && wb_q.wsel == ins.rt) ? wb_q.wdata : regs[ins.rt];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ctrl_q      <= ctrl_t'('0);
         trace_valid <= 1'b0;
         err         <= 1'b0;
      end else begin
         ctrl_q      <= bubble ? ctrl_t'('0) : ctrl;
         trace_valid <= wb_we;
         if (if_q.valid && illegal && !redirect.taken) begin
            err <= 1'b1;           // Sticky until reset
         end
      end
   end

   always_ff @(posedge clk) begin
      pc_next_q  <= if_q.pc_next;
      rs_val_q   <= rs_val;
      rt_val_q   <= rt_val;
      imm_q      <= imm;
      wsel_q     <= wsel;
      trace_reg  <= wb_q.wsel;     // Trace lags the register write by one cycle
      trace_data <= wb_q.wdata;
   end

   assign id_q = '{ctrl: ctrl_q, pc_next: pc_next_q, rs_val: rs_val_q,
                   rt_val: rt_val_q, imm: imm_q, wsel: wsel_q};
   assign trace = '{valid: trace_valid, reg_idx: trace_reg, data: trace_data};

endmodule

/* execute.sv */
// Execute stage with the ALU, branch and jump resolution and the EX/MEM register
`timescale 1ns/100ps
`include "cpu_defs.svh"

module execute (
   input  logic                clk,
   input  logic                arst_n,
   input  pipe_pkg::id_ex_t    id_q,
   output pipe_pkg::redirect_t redirect,
   output pipe_pkg::ex_mem_t   ex_q
);
   import isa_pkg::*;
   import pipe_pkg::*;

   logic [`CPU_XLEN-1:0]   opb;
   logic [`CPU_XLEN-1:0]   alu_res;
   logic [`CPU_XLEN-1:0]   alu_out;
   logic [`CPU_XLEN-1:0]   target;
   logic                   rs_zero;
   logic                   br_taken;
   ctrl_t                  ctrl_q;
   logic [`CPU_XLEN-1:0]   alu_out_q;
   logic [`CPU_XLEN-1:0]   store_val_q;
   logic [`CPU_RIDX_W-1:0] wsel_q;

   assign opb = id_q.ctrl.alu_src_imm ? id_q.imm : id_q.rt_val;

   always_comb begin
      case (id_q.ctrl.alu_op)
         ALU_ADD: alu_res = id_q.rs_val + opb;
         ALU_SUB: alu_res = id_q.rs_val - opb;
         ALU_AND: alu_res = id_q.rs_val & opb;
         ALU_XOR: alu_res = id_q.rs_val ^ opb;
         default: alu_res = id_q.rs_val + opb;
      endcase
   end

   assign alu_out = id_q.ctrl.imm_pass ? id_q.imm : alu_res;   // LBI

   // Branch condition on rs only, no flags
   assign rs_zero = (id_q.rs_val == '0);

   always_comb begin
      case (id_q.ctrl.branch)
         BR_ZERO:    br_taken = rs_zero;
         BR_NONZERO: br_taken = !rs_zero;
         default:    br_taken = 1'b0;
      endcase
   end

   // Offsets are relative to the already incremented PC
   assign target   = id_q.pc_next + id_q.imm;
   assign redirect = '{taken: id_q.ctrl.valid && (id_q.ctrl.jump || br_taken),
                       target: target};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ctrl_q <= ctrl_t'('0);
      end else begin
         ctrl_q <= id_q.ctrl;
      end
   end

   always_ff @(posedge clk) begin
      alu_out_q   <= alu_out;
      store_val_q <= id_q.rt_val;
      wsel_q      <= id_q.wsel;
   end

   assign ex_q = '{ctrl: ctrl_q, alu_out: alu_out_q, store_val: store_val_q, wsel: wsel_q};

endmodule

/* fetch.sv */
// Fetch stage holding the PC, run flag, loadable instruction memory and IF/ID register
`timescale 1ns/100ps
`include "cpu_defs.svh"

module fetch (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    start,
   input  logic                    imem_we,
   input  logic [`CPU_IMEM_AW-1:0] imem_addr,
   input  logic [`CPU_XLEN-1:0]    imem_wdata,
   input  logic                    stall,
   input  pipe_pkg::redirect_t     redirect,
   input  logic                    halt_seen,
   output pipe_pkg::if_id_t        if_q
);
   import isa_pkg::*;

   logic [`CPU_XLEN-1:0] imem [`CPU_IMEM_DEPTH];
   logic [`CPU_XLEN-1:0] pc;
   logic [`CPU_XLEN-1:0] pc_plus2;
   logic                 run;
   logic                 fetch_en;
   instr_t               word;
   logic                 valid_q;
   logic [`CPU_XLEN-1:0] pc_next_q;
   instr_t               instr_q;

   assign word     = instr_t'(imem[pc[`CPU_IMEM_AW:1]]);
   assign pc_plus2 = pc + 'd2;
   assign fetch_en = run && !start && !redirect.taken && !halt_seen && !stall;

   // Program load port, open at any time
   always_ff @(posedge clk) begin
      if (imem_we) begin
         imem[imem_addr] <= imem_wdata;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         run     <= 1'b0;
         pc      <= '0;
         valid_q <= 1'b0;
      end else if (start) begin
         run     <= 1'b1;
         pc      <= '0;
         valid_q <= 1'b0;
      end else if (redirect.taken) begin
         run     <= 1'b1;              // A wrong-path HALT may have paused fetch
         pc      <= redirect.target;
         valid_q <= 1'b0;
      end else if (halt_seen) begin
         run     <= 1'b0;
         valid_q <= 1'b0;
      end else if (!stall) begin
         valid_q <= run;
         if (run) begin
            pc <= pc_plus2;
            if (word.opcode == OP_HALT) begin
               run <= 1'b0;            // Stop at HALT, nothing beyond it is fetched
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fetch_en) begin
         instr_q   <= word;
         pc_next_q <= pc_plus2;
      end
   end

   assign if_q = '{valid: valid_q, pc_next: pc_next_q, instr: instr_q};

endmodule

/* filelist.f */
+incdir+.
isa_pkg.sv
pipe_pkg.sv
fetch.sv
hazard_unit.sv
decode.sv
execute.sv
memory_stage.sv
proc.sv
tb_proc.sv

/* hazard_unit.sv */
// Hazard unit that stalls decode on read-after-write conflicts with execute and memory
`timescale 1ns/100ps

module hazard_unit (
   input  isa_pkg::instr_t   instr,
   input  logic              valid,
   input  pipe_pkg::id_ex_t  id_q,
   input  pipe_pkg::ex_mem_t ex_q,
   output logic              stall
);
   import isa_pkg::*;

   logic reads_rs;
   logic reads_rt;
   logic ex_hit;
   logic mem_hit;

   // Only true source operands count
   always_comb begin
      reads_rs = 1'b0;
      reads_rt = 1'b0;
      case (instr.opcode)
         OP_ADDI, OP_LD, OP_BEQZ, OP_BNEZ: reads_rs = 1'b1;
         OP_ST, OP_RTYPE: begin
            reads_rs = 1'b1;
            reads_rt = 1'b1;       // ST data comes from rt
         end
         default: ;
      endcase
   end

   assign ex_hit = id_q.ctrl.valid && id_q.ctrl.reg_write &&
                   ((reads_rs && id_q.wsel == instr.rs) || (reads_rt && id_q.wsel == instr.rt));
   assign mem_hit = ex_q.ctrl.valid && ex_q.ctrl.reg_write &&
                    ((reads_rs && ex_q.wsel == instr.rs) || (reads_rt && ex_q.wsel == instr.rt));

   // Writeback is covered by the register file bypass
   assign stall = valid && (ex_hit || mem_hit);

endmodule

/* isa_pkg.sv */
// Instruction set encodings for the processor, with opcodes, ALU functions and field layout
`include "cpu_defs.svh"

package isa_pkg;

   // Major opcode in bits 15..11
   typedef enum logic [4:0] {
      OP_HALT  = 5'b00000,
      OP_NOP   = 5'b00001,
      OP_J     = 5'b00100,
      OP_ADDI  = 5'b01000,
      OP_BEQZ  = 5'b01100,
      OP_BNEZ  = 5'b01101,
      OP_ST    = 5'b10000,
      OP_LD    = 5'b10001,
      OP_LBI   = 5'b11000,
      OP_RTYPE = 5'b11011
   } opcode_e;

   // R-type function field, also the internal ALU select
   typedef enum logic [1:0] {
      ALU_ADD = 2'b00,
      ALU_SUB = 2'b01,   // rs - rt
      ALU_AND = 2'b10,
      ALU_XOR = 2'b11
   } alu_op_e;

   // Immediates overlay the low fields
   // imm5 is bits 4..0, imm8 is bits 7..0, imm11 is bits 10..0
   typedef struct packed {
      opcode_e                opcode;
      logic [`CPU_RIDX_W-1:0] rs;
      logic [`CPU_RIDX_W-1:0] rt;
      logic [`CPU_RIDX_W-1:0] rd;
      alu_op_e                funct;
   } instr_t;

endpackage

/* memory_stage.sv */
// Memory stage with the data memory, writeback data select and MEM/WB register
`timescale 1ns/100ps
`include "cpu_defs.svh"

module memory_stage (
   input  logic               clk,
   input  logic               arst_n,
   input  pipe_pkg::ex_mem_t  ex_q,
   output pipe_pkg::mem_wb_t  wb_q,
   output logic               halted
);
   logic [`CPU_XLEN-1:0]   dmem [`CPU_DMEM_DEPTH];
   logic [`CPU_DMEM_AW-1:0] addr;
   logic [`CPU_XLEN-1:0]   load_data;
   logic [`CPU_XLEN-1:0]   wdata;
   logic                   valid_q;
   logic                   reg_write_q;
   logic                   halt_q;
   logic                   halt_seen_q;
   logic [`CPU_RIDX_W-1:0] wsel_q;
   logic [`CPU_XLEN-1:0]   wdata_q;

   assign addr = ex_q.alu_out[`CPU_DMEM_AW:1];   // Word index from byte address

   always_ff @(posedge clk) begin
      if (ex_q.ctrl.valid && ex_q.ctrl.mem_write) begin
         dmem[addr] <= ex_q.store_val;
      end
   end

   assign load_data = dmem[addr];
   assign wdata     = ex_q.ctrl.mem_read ? load_data : ex_q.alu_out;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q     <= 1'b0;
         reg_write_q <= 1'b0;
         halt_q      <= 1'b0;
         halt_seen_q <= 1'b0;
      end else begin
         valid_q     <= ex_q.ctrl.valid;
         reg_write_q <= ex_q.ctrl.valid && ex_q.ctrl.reg_write;
         halt_q      <= ex_q.ctrl.valid && ex_q.ctrl.halt;
         if (halt_q) begin
            halt_seen_q <= 1'b1;   // Held until reset
         end
      end
   end

   always_ff @(posedge clk) begin
      wsel_q  <= ex_q.wsel;
      wdata_q <= wdata;
   end

   assign wb_q = '{valid: valid_q, reg_write: reg_write_q, halt: halt_q,
                   wsel: wsel_q, wdata: wdata_q};

   assign halted = wb_q.halt || halt_seen_q;   // Rises with HALT in writeback

endmodule

/* pipe_pkg.sv */
// Pipeline bundles for the processor, covering control, stage registers, redirect and trace
`include "cpu_defs.svh"

package pipe_pkg;

   typedef enum logic [1:0] {
      BR_NONE    = 2'b00,
      BR_ZERO    = 2'b01,
      BR_NONZERO = 2'b10
   } br_kind_e;

   typedef struct packed {
      logic             valid;
      logic             reg_write;
      logic             mem_read;
      logic             mem_write;
      logic             alu_src_imm;
      logic             imm_pass;     // LBI, immediate straight to the result
      br_kind_e         branch;
      logic             jump;
      logic             halt;
      isa_pkg::alu_op_e alu_op;
   } ctrl_t;

   typedef struct packed {
      logic                 valid;
      logic [`CPU_XLEN-1:0] pc_next;
      isa_pkg::instr_t      instr;
   } if_id_t;

   typedef struct packed {
      ctrl_t                  ctrl;
      logic [`CPU_XLEN-1:0]   pc_next;
      logic [`CPU_XLEN-1:0]   rs_val;
      logic [`CPU_XLEN-1:0]   rt_val;
      logic [`CPU_XLEN-1:0]   imm;
      logic [`CPU_RIDX_W-1:0] wsel;
   } id_ex_t;

   typedef struct packed {
      ctrl_t                  ctrl;
      logic [`CPU_XLEN-1:0]   alu_out;
      logic [`CPU_XLEN-1:0]   store_val;
      logic [`CPU_RIDX_W-1:0] wsel;
   } ex_mem_t;

   typedef struct packed {
      logic                   valid;
      logic                   reg_write;
      logic                   halt;
      logic [`CPU_RIDX_W-1:0] wsel;
      logic [`CPU_XLEN-1:0]   wdata;
   } mem_wb_t;

   typedef struct packed {
      logic                 taken;
      logic [`CPU_XLEN-1:0] target;
   } redirect_t;

   typedef struct packed {
      logic                   valid;
      logic [`CPU_RIDX_W-1:0] reg_idx;
      logic [`CPU_XLEN-1:0]   data;
   } wb_trace_t;

endpackage

/* proc.sv */
// Top level of the five-stage processor connecting fetch, decode, hazard, execute and memory
`timescale 1ns/100ps
`include "cpu_defs.svh"

module proc (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    imem_we,
   input  logic [`CPU_IMEM_AW-1:0] imem_addr,
   input  logic [`CPU_XLEN-1:0]    imem_wdata,
   input  logic                    start,
   output pipe_pkg::wb_trace_t     trace,
   output logic                    halted,
   output logic                    err
);
   import pipe_pkg::*;

   if_id_t    if_q;
   id_ex_t    id_q;
   ex_mem_t   ex_q;
   mem_wb_t   wb_q;
   redirect_t redirect;
   logic      stall;

   fetch u_fetch (
      .clk        (clk),
      .arst_n     (arst_n),
      .start      (start),
      .imem_we    (imem_we),
      .imem_addr  (imem_addr),
      .imem_wdata (imem_wdata),
      .stall      (stall),
      .redirect   (redirect),
      .halt_seen  (halted),
      .if_q       (if_q)
   );

   hazard_unit u_hazard (
      .instr (if_q.instr),
      .valid (if_q.valid),
      .id_q  (id_q),
      .ex_q  (ex_q),
      .stall (stall)
   );

   decode u_decode (
      .clk      (clk),
      .arst_n   (arst_n),
      .if_q     (if_q),
      .stall    (stall),
      .redirect (redirect),
      .wb_q     (wb_q),
      .id_q     (id_q),
      .trace    (trace),
      .err      (err)
   );

   execute u_execute (
      .clk      (clk),
      .arst_n   (arst_n),
      .id_q     (id_q),
      .redirect (redirect),
      .ex_q     (ex_q)
   );

   memory_stage u_memory (
      .clk    (clk),
      .arst_n (arst_n),
      .ex_q   (ex_q),
      .wb_q   (wb_q),
      .halted (halted)
   );

endmodule

/* proc_golden.txt */
# T <test name> | P <imem word index, hex> <instruction, hex> | W <reg> <value, hex> | E <final err>
# W lines follow retirement order, test 5 operands are xorshift16 (7,9,8) outputs from seed 64
T alu_ops
P 00 C105
P 01 C2FD
P 02 4167
P 03 D950
P 04 D955
P 05 D95A
P 06 D95F
P 07 0000
W 1 0005
W 2 FFFD
W 3 000C
W 4 0002
W 5 0008
W 6 0005
W 7 FFF8
E 0
T dependent_chain
P 00 C110
P 01 4141
P 02 DA4C
P 03 DB25
P 04 0000
W 1 0010
W 2 0011
W 3 0022
W 1 0012
E 0
T load_store
P 00 C120
P 01 C25A
P 02 C3FF
P 03 8162
P 04 8140
P 05 8980
P 06 89A2
P 07 0000
W 1 0020
W 2 005A
W 3 FFFF
W 4 005A
W 5 FFFF
E 0
T branch_jump
P 00 C100
P 01 C203
P 02 6104
P 03 C311
P 04 C422
P 05 6904
P 06 C533
P 07 6A04
P 08 C644
P 09 C755
P 0A 2004
P 0B C366
P 0C C477
P 0D C67F
P 0E 0000
W 1 0000
W 2 0003
W 5 0033
W 6 007F
E 0
T random_chain
P 00 C150
P 01 C27C
P 02 C371
P 03 C498
P 04 D954
P 05 DD7B
P 06 DE9D
P 07 DF86
P 08 0000
P 09 C201
W 1 0050
W 2 007C
W 3 0071
W 4 FF98
W 5 00CC
W 6 00BD
W 7 0125
W 1 0100
E 0
T illegal_opcode
P 00 C10A
P 01 FB33
P 02 415F
P 03 0000
W 1 000A
W 2 0009
E 1

/* tb_proc.sv */
// Self-checking testbench for the pipelined processor, driven by programs from the golden file
`timescale 1ns/100ps
`include "cpu_defs.svh"

module tb_proc;
   import pipe_pkg::*;

   logic                    clk;
   logic                    arst_n;
   logic                    imem_we;
   logic [`CPU_IMEM_AW-1:0] imem_addr;
   logic [`CPU_XLEN-1:0]    imem_wdata;
   logic                    start;
   wb_trace_t               trace;
   logic                    halted;
   logic                    err;

   string                   lines[$];        // Raw golden file lines
   string                   test_name;
   logic [`CPU_IMEM_AW-1:0] prog_addr[$];
   logic [`CPU_XLEN-1:0]    prog_word[$];
   wb_trace_t               exp_writes[$];   // Retirement order
   logic                    exp_err;
   int                      timeout_cycles = 0;
   int                      trace_errors = 0;
   int                      flag_errors = 0;
   int                      other_errors = 0;
   int                      tests_run = 0;

   proc i_dut (
      .clk        (clk),
      .arst_n     (arst_n),
      .imem_we    (imem_we),
      .imem_addr  (imem_addr),
      .imem_wdata (imem_wdata),
      .start      (start),
      .trace      (trace),
      .halted     (halted),
      .err        (err)
   );

   always #5 clk = ~clk;

   task automatic compare_trace(input string name, input wb_trace_t exp_entry,
                                input wb_trace_t act_entry);
      if (act_entry.reg_idx !== exp_entry.reg_idx || act_entry.data !== exp_entry.data) begin
         $display("[ERROR] %s: write expected r%0d = %h, actual r%0d = %h", name,
                  exp_entry.reg_idx, exp_entry.data, act_entry.reg_idx, act_entry.data);
         trace_errors++;
      end
   endtask

   task automatic compare_flag(input string name, input string flag, input logic exp_val,
                               input logic act_val);
      if (act_val !== exp_val) begin
         $display("[ERROR] %s: %s expected %b, actual %b", name, flag, exp_val, act_val);
         flag_errors++;
      end
   endtask

   // Match one trace entry against the next expected write
   task automatic take_trace();
      wb_trace_t exp_entry;
      if (exp_writes.size() == 0) begin
         $display("%s: unexpected write of %h to r%0d, no more writes were expected",
                  test_name, trace.data, trace.reg_idx);
         other_errors++;
      end else begin
         exp_entry = exp_writes.pop_front();
         compare_trace(test_name, exp_entry, trace);
      end
   endtask

   task automatic apply_reset();
      @(negedge clk);
      arst_n = 1'b0;
      repeat (3) @(negedge clk);
      arst_n = 1'b1;
   endtask

   task automatic load_program();
      for (int i = 0; i < prog_addr.size(); i++) begin
         @(negedge clk);
         imem_we    = 1'b1;
         imem_addr  = prog_addr[i];
         imem_wdata = prog_word[i];
      end
      @(negedge clk);
      imem_we = 1'b0;
   endtask

   task automatic run_test();
      int limit;
      int cycles;
      limit  = 20 * prog_addr.size() + 50;   // Room for stalls and flushes
      cycles = 0;
      apply_reset();
      load_program();
      start = 1'b1;                  // One-cycle strobe
      @(negedge clk);
      start = 1'b0;
      while (!halted && cycles < limit) begin
         @(negedge clk);
         cycles++;
         if (trace.valid) begin
            take_trace();
         end
      end
      // HALT has retired, so any further write is a failure
      repeat (6) begin
         @(negedge clk);
         if (trace.valid) begin
            take_trace();
         end
      end
      if (exp_writes.size() != 0) begin
         $display("%s: %0d expected register writes never appeared", test_name,
                  exp_writes.size());
         other_errors++;
      end
      compare_flag(test_name, "halted", 1'b1, halted);
      compare_flag(test_name, "err", exp_err, err);
      tests_run++;
   endtask

   initial begin : watchdog
      wait (timeout_cycles > 0);
      repeat (timeout_cycles) @(posedge clk);
      $display("Timeout after %0d cycles, the processor did not finish all tests",
               timeout_cycles);
      $display("Regression failed");
      $finish;
   end

   initial begin : main
      int                      fd;
      int                      n_prog;
      int                      reg_i;
      int                      errors;
      string                   line;
      byte                     tag;
      bit                      have_test;
      logic [`CPU_IMEM_AW-1:0] addr;
      logic [`CPU_XLEN-1:0]    val;
      wb_trace_t               entry;

      clk        = 1'b0;
      arst_n     = 1'b0;
      imem_we    = 1'b0;
      imem_addr  = '0;
      imem_wdata = '0;
      start      = 1'b0;
      have_test  = 1'b0;
      n_prog     = 0;

      fd = $fopen("proc_golden.txt", "r");
      if (fd == 0) begin
         $display("Cannot open proc_golden.txt, so no test could run");
         other_errors++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0) begin
               lines.push_back(line);
            end
         end
         $fclose(fd);
      end

      foreach (lines[i]) begin
         if (lines[i].getc(0) == "P") begin
            n_prog++;
         end
      end
      timeout_cycles = 200 * n_prog + 100;

      foreach (lines[i]) begin
         line = lines[i];
         tag  = line.getc(0);
         case (tag)
            "T": begin
               if (have_test) begin
                  run_test();       // Previous test is complete
               end
               void'($sscanf(line, "T %s", test_name));
               prog_addr.delete();
               prog_word.delete();
               exp_writes.delete();
               exp_err   = 1'b0;
               have_test = 1'b1;
            end
            "P": begin
               if ($sscanf(line, "P %h %h", addr, val) == 2) begin
                  prog_addr.push_back(addr);
                  prog_word.push_back(val);
               end else begin
                  $display("Malformed program line in the golden file: %s", line);
                  other_errors++;
               end
            end
            "W": begin
               if ($sscanf(line, "W %d %h", reg_i, val) == 2) begin
                  entry.valid   = 1'b1;
                  entry.reg_idx = reg_i[`CPU_RIDX_W-1:0];
                  entry.data    = val;
                  exp_writes.push_back(entry);
               end else begin
                  $display("Malformed write line in the golden file: %s", line);
                  other_errors++;
               end
            end
            "E": begin
               void'($sscanf(line, "E %d", reg_i));
               exp_err = (reg_i != 0);
            end
            "#", " ", "\n", "\r", 8'd0: ;
            default: begin
               $display("Unrecognized line in the golden file: %s", line);
               other_errors++;
            end
         endcase
      end
      if (have_test) begin
         run_test();
      end
      if (tests_run == 0) begin
         $display("The golden file held no tests");
         other_errors++;
      end

      errors = trace_errors + flag_errors + other_errors;
      $display("Ran %0d tests, %0d errors: %0d trace, %0d flag, %0d other", tests_run,
               errors, trace_errors, flag_errors, other_errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule
